//--- sources.f
+incdir+.
gat_pkg.sv
node_projector.sv
node_fifo.sv
aggregator.sv
gat_layer_top.sv
tb_gat_layer.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the GAT layer testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_gat_layer -Mdir obj_dir -f sources.f; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_gat_layer)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
  echo "Simulation binary exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Simulation passed"; then
  exit 0
fi
exit 1

//--- tb_gat_layer.sv
`include "gat_consts.svh"

module tb_gat_layer import gat_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NF      = `GAT_NUM_FEAT_OUT;
  localparam int NUM_W   = `GAT_NUM_FEAT_IN * `GAT_NUM_FEAT_OUT;
  localparam int TIMEOUT = 1000;

  logic                    clk;
  logic                    rst_n;
  logic                    entry_req;
  logic                    entry_ack;
  data_t                   entry_val;
  col_t                    entry_col;
  logic                    entry_last;
  logic                    entry_end;
  logic                    wgt_we;
  logic [`GAT_WADDR_W-1:0] wgt_addr;
  data_t                   wgt_data;
  logic                    feat_req;
  feat_vec_t               feat;
  logic                    feat_ack;

  integer seed = 32'hd7a5;
  int     err_count;
  int     timeout_count;

  // Mirror of the weight file
  data_t w_ref [NUM_W];
  data_t a_ref [NF];

  // Pending stimulus and expected results
  data_t     val_q  [$];
  col_t      col_q  [$];
  logic      last_q [$];
  logic      end_q  [$];
  feat_vec_t exp_q  [$];

  gat_layer_top dut_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .entry_req_i  (entry_req),
    .entry_ack_o  (entry_ack),
    .entry_val_i  (entry_val),
    .entry_col_i  (entry_col),
    .entry_last_i (entry_last),
    .entry_end_i  (entry_end),
    .wgt_we_i     (wgt_we),
    .wgt_addr_i   (wgt_addr),
    .wgt_data_i   (wgt_data),
    .feat_req_o   (feat_req),
    .feat_o       (feat),
    .feat_ack_i   (feat_ack)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("MISMATCH time=%0t %s expected=%b actual=%b", $time, name, exp, act);
      err_count++;
    end
  endtask

  task automatic check_feat(input string name, input acc_t exp, input acc_t act);
    if (act !== exp) begin
      $display("MISMATCH time=%0t %s expected=%0d actual=%0d", $time, name, exp, act);
      err_count++;
    end
  endtask

  task automatic load_weight(input int addr, input data_t data);
    @(negedge clk);
    wgt_we   = 1'b1;
    wgt_addr = addr[`GAT_WADDR_W-1:0];
    wgt_data = data;
    if (addr < `GAT_A_BASE) begin
      w_ref[addr] = data;
    end else begin
      a_ref[addr - `GAT_A_BASE] = data;
    end
    @(negedge clk);
    wgt_we = 1'b0;
  endtask

  task automatic load_random_weights();
    for (int i = 0; i < NUM_W; i++) begin
      load_weight(i, data_t'($random(seed)));
    end
    for (int f = 0; f < NF; f++) begin
      load_weight(`GAT_A_BASE + f, data_t'($random(seed)));
    end
  endtask

  // Queue one subgraph of random entries and its expected features
  task automatic build_subgraph(input int num_nodes, input int max_entries,
                                input col_t col_mask, input bit force_neg);
    longint    wh  [NF];
    longint    sum [NF];
    longint    coef;
    int        n_ent;
    data_t     val;
    col_t      col;
    feat_vec_t exp;
    foreach (sum[f]) sum[f] = 0;
    for (int node = 0; node < num_nodes; node++) begin
      n_ent = 1 + int'($unsigned($random(seed)) % max_entries);
      foreach (wh[f]) wh[f] = 0;
      for (int e = 0; e < n_ent; e++) begin
        val = data_t'($random(seed));
        if (force_neg && e == 0) begin
          val[`GAT_DATA_W-1] = 1'b1;
        end
        col = col_t'($random(seed)) & col_mask;
        for (int f = 0; f < NF; f++) begin
          wh[f] += longint'(val) * longint'(w_ref[int'(col) * NF + f]);
        end
        val_q.push_back(val);
        col_q.push_back(col);
        last_q.push_back(e == n_ent - 1);
        end_q.push_back(e == n_ent - 1 && node == num_nodes - 1);
      end
      coef = 0;
      for (int f = 0; f < NF; f++) begin
        coef += longint'(a_ref[f]) * wh[f];
      end
      for (int f = 0; f < NF; f++) begin
        sum[f] += coef * wh[f];
      end
    end
    for (int f = 0; f < NF; f++) begin
      exp[f] = acc_t'(sum[f]);
    end
    exp_q.push_back(exp);
  endtask

  task automatic send_entry(input data_t val, input col_t col, input logic last,
                            input logic end_flag, output bit ok);
    int cnt;
    ok = 1'b1;
    @(negedge clk);
    entry_req  = 1'b1;
    entry_val  = val;
    entry_col  = col;
    entry_last = last;
    entry_end  = end_flag;
    cnt = 0;
    while (entry_ack !== 1'b1 && cnt < TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (entry_ack !== 1'b1) begin
      $display("Timeout at %0t: entry_ack_o never rose", $time);
      timeout_count++;
      ok = 1'b0;
    end
    entry_req = 1'b0;
    if (ok) begin
      cnt = 0;
      while (entry_ack !== 1'b0 && cnt < TIMEOUT) begin
        @(negedge clk);
        cnt++;
      end
      if (entry_ack !== 1'b0) begin
        $display("Timeout at %0t: entry_ack_o stayed high after req dropped", $time);
        timeout_count++;
        ok = 1'b0;
      end
    end
  endtask

  task automatic send_all();
    bit ok;
    ok = 1'b1;
    for (int i = 0; i < val_q.size() && ok; i++) begin
      send_entry(val_q[i], col_q[i], last_q[i], end_q[i], ok);
    end
  endtask

  // Wait for a result, compare it, hold ack back, then finish the handshake
  task automatic expect_feat(input feat_vec_t exp, input int ack_delay, input bit stall_check);
    int        cnt;
    feat_vec_t held;
    cnt = 0;
    while (feat_req !== 1'b1 && cnt < TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (feat_req !== 1'b1) begin
      $display("Timeout at %0t: feat_req_o never rose", $time);
      timeout_count++;
      return;
    end
    for (int f = 0; f < NF; f++) begin
      check_feat($sformatf("feat_o[%0d]", f), exp[f], feat[f]);
    end
    held = feat;
    repeat (ack_delay) begin
      @(negedge clk);
      check_bit("feat_req_o", 1'b1, feat_req);
      for (int f = 0; f < NF; f++) begin
        check_feat($sformatf("feat_o[%0d]", f), held[f], feat[f]);
      end
    end
    // Input side must be stalled by now, with an entry still waiting
    if (stall_check) begin
      check_bit("entry_req_i", 1'b1, entry_req);
      check_bit("entry_ack_o", 1'b0, entry_ack);
    end
    feat_ack = 1'b1;
    cnt = 0;
    while (feat_req !== 1'b0 && cnt < TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (feat_req !== 1'b0) begin
      $display("Timeout at %0t: feat_req_o stayed high after ack", $time);
      timeout_count++;
    end
    feat_ack = 1'b0;
  endtask

  task automatic receive_all(input int n, input int first_delay, input bit stall_check);
    feat_vec_t exp;
    for (int i = 0; i < n; i++) begin
      exp = exp_q.pop_front();
      expect_feat(exp, (i == 0) ? first_delay : 0, stall_check && i == 0);
    end
  endtask

  task automatic run_queued(input int first_delay, input bit stall_check);
    int n;
    n = exp_q.size();
    fork
      send_all();
      receive_all(n, first_delay, stall_check);
    join
    val_q.delete();
    col_q.delete();
    last_q.delete();
    end_q.delete();
  endtask

  task automatic reset_zero_features();
    @(negedge clk);
    check_bit("entry_ack_o", 1'b0, entry_ack);
    check_bit("feat_req_o", 1'b0, feat_req);
    build_subgraph(1, 1, 4'hf, 1'b0);
    run_queued(0, 1'b0);
  endtask

  task automatic single_node_score();
    load_random_weights();
    build_subgraph(1, 1, 4'hf, 1'b0);
    run_queued(0, 1'b0);
  endtask

  // Narrow column mask forces repeated columns
  task automatic sparse_multi_node();
    build_subgraph(3, 4, 4'h3, 1'b1);
    run_queued(0, 1'b0);
  endtask

  task automatic back_to_back_subgraphs();
    load_random_weights();
    for (int s = 0; s < 4; s++) begin
      build_subgraph(1 + int'($unsigned($random(seed)) % 8), 4, 4'hf, 1'b0);
    end
    run_queued(0, 1'b0);
  endtask

  task automatic output_back_pressure();
    build_subgraph(8, 3, 4'hf, 1'b0);
    build_subgraph(8, 1, 4'hf, 1'b0);
    run_queued(60, 1'b1);
  endtask

  initial begin
    err_count     = 0;
    timeout_count = 0;
    for (int i = 0; i < NUM_W; i++) begin
      w_ref[i] = '0;
    end
    for (int f = 0; f < NF; f++) begin
      a_ref[f] = '0;
    end
    rst_n      = 1'b0;
    entry_req  = 1'b0;
    entry_val  = '0;
    entry_col  = '0;
    entry_last = 1'b0;
    entry_end  = 1'b0;
    wgt_we     = 1'b0;
    wgt_addr   = '0;
    wgt_data   = '0;
    feat_ack   = 1'b0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;

    reset_zero_features();
    single_node_score();
    sparse_multi_node();
    back_to_back_subgraphs();
    output_back_pressure();

    $display("Errors: %0d mismatches, %0d timeouts", err_count, timeout_count);
    if (err_count == 0 && timeout_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- gat_layer_top.sv
`include "gat_consts.svh"

module gat_layer_top import gat_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    entry_req_i,
  output logic                    entry_ack_o,
  input  data_t                   entry_val_i,
  input  col_t                    entry_col_i,
  input  logic                    entry_last_i,
  input  logic                    entry_end_i,
  input  logic                    wgt_we_i,
  input  logic [`GAT_WADDR_W-1:0] wgt_addr_i,
  input  data_t                   wgt_data_i,
  output logic                    feat_req_o,
  output feat_vec_t               feat_o,
  input  logic                    feat_ack_i
);

  logic       node_push;
  node_word_t node_word;
  logic       fifo_full;
  node_word_t head_word;
  logic       fifo_empty;
  logic       fifo_pop;

  node_projector u_projector (
    .clk          (clk),
    .rst_n        (rst_n),
    .entry_req_i  (entry_req_i),
    .entry_ack_o  (entry_ack_o),
    .entry_val_i  (entry_val_i),
    .entry_col_i  (entry_col_i),
    .entry_last_i (entry_last_i),
    .entry_end_i  (entry_end_i),
    .wgt_we_i     (wgt_we_i),
    .wgt_addr_i   (wgt_addr_i),
    .wgt_data_i   (wgt_data_i),
    .node_push_o  (node_push),
    .node_word_o  (node_word),
    .fifo_full_i  (fifo_full)
  );

  node_fifo u_fifo (
    .clk          (clk),
    .rst_n        (rst_n),
    .push_i       (node_push),
    .push_word_i  (node_word),
    .full_o       (fifo_full),
    .pop_i        (fifo_pop),
    .head_word_o  (head_word),
    .empty_o      (fifo_empty)
  );

  aggregator u_aggregator (
    .clk          (clk),
    .rst_n        (rst_n),
    .head_word_i  (head_word),
    .fifo_empty_i (fifo_empty),
    .pop_o        (fifo_pop),
    .feat_req_o   (feat_req_o),
    .feat_o       (feat_o),
    .feat_ack_i   (feat_ack_i)
  );

endmodule

//--- aggregator.sv
`include "gat_consts.svh"

module aggregator import gat_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  node_word_t head_word_i,
  input  logic       fifo_empty_i,
  output logic       pop_o,
  output logic       feat_req_o,
  output feat_vec_t  feat_o,
  input  logic       feat_ack_i
);

  localparam int F_IDX_W = $clog2(`GAT_NUM_FEAT_OUT);

  aggr_state_e        state_q;
  logic [F_IDX_W-1:0] mac_idx_q;
  node_word_t         word_q;
  feat_vec_t          feat_q;

  // Take the next node whenever idle
  assign pop_o = (state_q == AGGR_IDLE) && !fifo_empty_i;

  // Latched node word
  always_ff @(posedge clk) begin
    if (pop_o) begin
      word_q <= head_word_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= AGGR_IDLE;
      mac_idx_q <= '0;
      feat_q    <= '0;
    end else begin
      case (state_q)
        AGGR_IDLE: begin
          if (pop_o) begin
            mac_idx_q <= '0;
            state_q   <= AGGR_MAC;
          end
        end
        AGGR_MAC: begin
          feat_q[mac_idx_q] <= feat_q[mac_idx_q] + word_q.coef * word_q.wh[mac_idx_q];
          mac_idx_q         <= mac_idx_q + 1'b1;
          if (mac_idx_q == F_IDX_W'(`GAT_NUM_FEAT_OUT - 1)) begin
            state_q <= word_q.end_flag ? AGGR_REQ : AGGR_IDLE;
          end
        end
        AGGR_REQ: begin
          if (feat_ack_i) begin
            state_q <= AGGR_RELEASE;
          end
        end
        AGGR_RELEASE: begin
          // Sum restarts for the next subgraph once ack is gone
          if (!feat_ack_i) begin
            feat_q  <= '0;
            state_q <= AGGR_IDLE;
          end
        end
        default: state_q <= AGGR_IDLE;
      endcase
    end
  end

  assign feat_req_o = (state_q == AGGR_REQ);
  assign feat_o     = feat_q;

endmodule

//--- node_fifo.sv
`include "gat_consts.svh"

module node_fifo import gat_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       push_i,
  input  node_word_t push_word_i,
  output logic       full_o,
  input  logic       pop_i,
  output node_word_t head_word_o,
  output logic       empty_o
);

  localparam int DEPTH = `GAT_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  node_word_t       mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   count_q;
  logic             do_push;
  logic             do_pop;

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_word_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Show-ahead head
  assign head_word_o = mem_q[rd_ptr_q];
  assign full_o      = (count_q == (PTR_W + 1)'(DEPTH));
  assign empty_o     = (count_q == '0);

  a_no_overflow: assert property (
    @(posedge clk) disable iff (!rst_n) push_i |-> !full_o
  ) else $error("push into full node FIFO");

  a_no_underflow: assert property (
    @(posedge clk) disable iff (!rst_n) pop_i |-> !empty_o
  ) else $error("pop from empty node FIFO");

endmodule

//--- node_projector.sv
`include "gat_consts.svh"

module node_projector import gat_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    entry_req_i,
  output logic                    entry_ack_o,
  input  data_t                   entry_val_i,
  input  col_t                    entry_col_i,
  input  logic                    entry_last_i,
  input  logic                    entry_end_i,
  input  logic                    wgt_we_i,
  input  logic [`GAT_WADDR_W-1:0] wgt_addr_i,
  input  data_t                   wgt_data_i,
  output logic                    node_push_o,
  output node_word_t              node_word_o,
  input  logic                    fifo_full_i
);

  localparam int NUM_W   = `GAT_NUM_FEAT_IN * `GAT_NUM_FEAT_OUT;
  localparam int W_IDX_W = $clog2(NUM_W);
  localparam int F_IDX_W = $clog2(`GAT_NUM_FEAT_OUT);

  proj_state_e          state_q;
  logic                 ack_q;
  logic                 take;
  logic [F_IDX_W-1:0]   score_idx_q;
  wh_vec_t              wh_q;
  coef_t                coef_q;
  logic                 end_q;

  data_t w_q [NUM_W];
  data_t a_q [`GAT_NUM_FEAT_OUT];

  // Weight and attention register file
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_W; i++) begin
        w_q[i] <= '0;
      end
      for (int f = 0; f < `GAT_NUM_FEAT_OUT; f++) begin
        a_q[f] <= '0;
      end
    end else if (wgt_we_i) begin
      if (wgt_addr_i < `GAT_A_BASE) begin
        w_q[wgt_addr_i[W_IDX_W-1:0]] <= wgt_data_i;
      end else if (wgt_addr_i < `GAT_A_BASE + `GAT_NUM_FEAT_OUT) begin
        a_q[wgt_addr_i[F_IDX_W-1:0]] <= wgt_data_i;
      end
    end
  end

  // New entry only while collecting a node and the previous ack is gone
  assign take = entry_req_i && !ack_q &&
                (state_q == PROJ_IDLE || state_q == PROJ_ACCUM);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
    end else if (take) begin
      ack_q <= 1'b1;
    end else if (!entry_req_i) begin
      ack_q <= 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= PROJ_IDLE;
      score_idx_q <= '0;
      wh_q        <= '0;
      coef_q      <= '0;
      end_q       <= 1'b0;
    end else begin
      case (state_q)
        PROJ_IDLE, PROJ_ACCUM: begin
          if (take) begin
            for (int f = 0; f < `GAT_NUM_FEAT_OUT; f++) begin
              wh_q[f] <= wh_q[f] + entry_val_i * w_q[{entry_col_i, F_IDX_W'(f)}];
            end
            end_q       <= entry_end_i;
            score_idx_q <= '0;
            state_q     <= entry_last_i ? PROJ_SCORE : PROJ_ACCUM;
          end
        end
        PROJ_SCORE: begin
          // One attention product per cycle
          coef_q      <= coef_q + a_q[score_idx_q] * wh_q[score_idx_q];
          score_idx_q <= score_idx_q + 1'b1;
          if (score_idx_q == F_IDX_W'(`GAT_NUM_FEAT_OUT - 1)) begin
            state_q <= PROJ_PUSH;
          end
        end
        PROJ_PUSH: begin
          if (!fifo_full_i) begin
            wh_q    <= '0;
            coef_q  <= '0;
            state_q <= PROJ_IDLE;
          end
        end
        default: state_q <= PROJ_IDLE;
      endcase
    end
  end

  assign entry_ack_o = ack_q;
  assign node_push_o = (state_q == PROJ_PUSH) && !fifo_full_i;

  assign node_word_o.end_flag = end_q;
  assign node_word_o.coef     = coef_q;
  assign node_word_o.wh       = wh_q;

  a_wgt_write_idle: assert property (
    @(posedge clk) disable iff (!rst_n)
    wgt_we_i |-> state_q == PROJ_IDLE
  ) else $error("weight write while projector is busy");

endmodule

//--- gat_pkg.sv
package gat_pkg;

`include "gat_consts.svh"

  typedef logic signed [`GAT_DATA_W-1:0] data_t;
  typedef logic        [`GAT_COL_W-1:0]  col_t;
  typedef logic signed [`GAT_WH_W-1:0]   wh_t;
  typedef logic signed [`GAT_COEF_W-1:0] coef_t;
  typedef logic signed [`GAT_ACC_W-1:0]  acc_t;

  typedef wh_t  [`GAT_NUM_FEAT_OUT-1:0] wh_vec_t;
  typedef acc_t [`GAT_NUM_FEAT_OUT-1:0] feat_vec_t;

  // One projected node, end flag in the top bit
  typedef struct packed {
    logic    end_flag;
    coef_t   coef;
    wh_vec_t wh;
  } node_word_t;

  typedef enum logic [1:0] {
    PROJ_IDLE, PROJ_ACCUM, PROJ_SCORE, PROJ_PUSH
  } proj_state_e;

  typedef enum logic [1:0] {
    AGGR_IDLE, AGGR_MAC, AGGR_REQ, AGGR_RELEASE
  } aggr_state_e;

endpackage

//--- gat_consts.svh
`ifndef GAT_CONSTS_SVH
`define GAT_CONSTS_SVH

// Input values, weights and attention elements
`define GAT_DATA_W        8

// Sparse input columns
`define GAT_NUM_FEAT_IN   16
`define GAT_COL_W         4

// Projected features per node
`define GAT_NUM_FEAT_OUT  4

// Accumulator widths along the datapath
`define GAT_WH_W          20
`define GAT_COEF_W        30
`define GAT_ACC_W         56

`define GAT_FIFO_DEPTH    4

// Weight file map: W[col][f] at col*4+f, attention from GAT_A_BASE
`define GAT_WADDR_W       7
`define GAT_A_BASE        64

`endif
